/* source/calc_cfg.svh */
`ifndef CALC_CFG_SVH
`define CALC_CFG_SVH

// datapath widths.
`define CALC_CODE_W 8
`define CALC_DIGIT_W 4
`define CALC_OPND_DIGITS 2
`define CALC_OPND_W 7
`define CALC_RES_DIGITS 4
`define CALC_BIN_W 14

// keypad make codes, digits first.
`define CALC_KEY_0 8'h45
`define CALC_KEY_1 8'h16
`define CALC_KEY_2 8'h1E
`define CALC_KEY_3 8'h26
`define CALC_KEY_4 8'h25
`define CALC_KEY_5 8'h2E
`define CALC_KEY_6 8'h36
`define CALC_KEY_7 8'h3D
`define CALC_KEY_8 8'h3E
`define CALC_KEY_9 8'h46

`define CALC_KEY_ADD 8'h79   // keypad plus.
`define CALC_KEY_SUB 8'h7B   // keypad minus.
`define CALC_KEY_MUL 8'h7C   // keypad star.
`define CALC_KEY_ENTER 8'h5A

`endif

/* source/calcPkg.sv */
`include "calc_cfg.svh"

package calcPkg;

	// what a decoded key stands for.
	typedef enum logic [1:0] {
		keyNone,
		keyDigit,
		keyOp,
		keyEnter
	} keyKindE;

	typedef enum logic [1:0] {
		opAdd,
		opSub,
		opMul
	} calcOpE;

	// entry state of the calculator.
	typedef enum logic [1:0] {
		stEntryA,   // building operand A.
		stEntryB,   // building operand B.
		stShown     // result on display.
	} calcStateE;

	typedef logic [`CALC_DIGIT_W-1:0] bcdDigitT;

endpackage

/* source/keyIf.sv */
interface keyIf;

	logic valid;
	calcPkg::keyKindE kind;
	calcPkg::bcdDigitT digit;   // meaningful for digit keys.
	calcPkg::calcOpE op;        // meaningful for operator keys.

	modport src (
		output valid,
		output kind,
		output digit,
		output op
	);

	modport dst (
		input valid,
		input kind,
		input digit,
		input op
	);

endinterface

/* source/opIf.sv */
`include "calc_cfg.svh"

interface opIf;

	logic go;   // one cycle, operands stable.
	logic [`CALC_OPND_W-1:0] opndA;
	logic [`CALC_OPND_W-1:0] opndB;
	calcPkg::calcOpE op;

	modport src (
		output go,
		output opndA,
		output opndB,
		output op
	);

	modport dst (
		input go,
		input opndA,
		input opndB,
		input op
	);

endinterface

/* source/keyDecode.sv */
`include "calc_cfg.svh"

module keyDecode (
	input logic clk,
	input logic rst,
	input logic keyValid,
	input logic [`CALC_CODE_W-1:0] scanCode,
	keyIf.src key
);

	localparam int CodeW = `CALC_CODE_W;
	localparam logic [CodeW-1:0] DigitCodes [10] = '{
		`CALC_KEY_0, `CALC_KEY_1, `CALC_KEY_2, `CALC_KEY_3, `CALC_KEY_4,
		`CALC_KEY_5, `CALC_KEY_6, `CALC_KEY_7, `CALC_KEY_8, `CALC_KEY_9
	};

	calcPkg::keyKindE kindNext;
	calcPkg::bcdDigitT digitNext;
	calcPkg::calcOpE opNext;

	always_comb begin
		kindNext = calcPkg::keyNone;
		digitNext = '0;
		opNext = calcPkg::opAdd;
		case (scanCode)
			`CALC_KEY_ADD: begin
				kindNext = calcPkg::keyOp;
				opNext = calcPkg::opAdd;
			end
			`CALC_KEY_SUB: begin
				kindNext = calcPkg::keyOp;
				opNext = calcPkg::opSub;
			end
			`CALC_KEY_MUL: begin
				kindNext = calcPkg::keyOp;
				opNext = calcPkg::opMul;
			end
			`CALC_KEY_ENTER: kindNext = calcPkg::keyEnter;
			default: begin
				// table position is the digit value.
				for (int i = 0; i < 10; i++) begin
					if (scanCode == DigitCodes[i]) begin
						kindNext = calcPkg::keyDigit;
						digitNext = calcPkg::bcdDigitT'(i);
					end
				end
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			key.valid <= 1'b0;
			key.kind <= calcPkg::keyNone;
		end else begin
			key.valid <= keyValid && (kindNext != calcPkg::keyNone);   // unknown codes dropped.
			key.kind <= kindNext;
		end
	end

	always_ff @(posedge clk) begin
		if (keyValid) begin
			key.digit <= digitNext;
			key.op <= opNext;
		end
	end

endmodule

/* source/calcExecute.sv */
`include "calc_cfg.svh"

module calcExecute (
	input logic clk,
	input logic rst,
	keyIf.dst key,
	opIf.src calc
);

	localparam int OpndW = `CALC_OPND_W;
	localparam int Digits = `CALC_OPND_DIGITS;
	localparam int DigitW = `CALC_DIGIT_W;

	calcPkg::calcStateE state;
	calcPkg::calcOpE opSel;
	calcPkg::bcdDigitT [Digits-1:0] bcdA;   // index 0 is the units digit.
	calcPkg::bcdDigitT [Digits-1:0] bcdB;

	logic isDigit;
	logic isOp;
	logic isEnter;
	logic compute;

	// packed BCD operand to binary, tens first.
	function automatic logic [OpndW-1:0] bcdToBin(input calcPkg::bcdDigitT [Digits-1:0] bcd);
		logic [OpndW-1:0] acc;
		acc = '0;
		for (int i = Digits - 1; i >= 0; i--) begin
			acc = acc * OpndW'(10) + OpndW'(bcd[i]);
		end
		return acc;
	endfunction

	assign isDigit = key.valid && (key.kind == calcPkg::keyDigit);
	assign isOp = key.valid && (key.kind == calcPkg::keyOp);
	assign isEnter = key.valid && (key.kind == calcPkg::keyEnter);
	assign compute = isEnter && (state == calcPkg::stEntryB);

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= calcPkg::stEntryA;
			opSel <= calcPkg::opAdd;
			bcdA <= '0;
			bcdB <= '0;
			calc.go <= 1'b0;
		end else begin
			calc.go <= compute;
			case (state)
				calcPkg::stEntryA: begin
					if (isDigit) begin
						bcdA <= {bcdA[Digits-2:0], key.digit};   // old tens digit falls off.
					end else if (isOp) begin
						opSel <= key.op;
						state <= calcPkg::stEntryB;
					end
				end
				calcPkg::stEntryB: begin
					if (isDigit) begin
						bcdB <= {bcdB[Digits-2:0], key.digit};
					end else if (isEnter) begin
						state <= calcPkg::stShown;
					end
				end
				calcPkg::stShown: begin
					// a digit here starts a new calculation.
					if (isDigit) begin
						bcdA <= {{((Digits - 1) * DigitW){1'b0}}, key.digit};
						bcdB <= '0;
						state <= calcPkg::stEntryA;
					end
				end
				default: state <= calcPkg::stEntryA;
			endcase
		end
	end

	// operands captured with the enter key, held for the go cycle and after.
	always_ff @(posedge clk) begin
		if (compute) begin
			calc.opndA <= bcdToBin(bcdA);
			calc.opndB <= bcdToBin(bcdB);
		end
	end

	assign calc.op = opSel;   // only changes in stEntryA.

endmodule

/* source/resultFormat.sv */
`include "calc_cfg.svh"

module resultFormat (
	input logic clk,
	input logic rst,
	opIf.dst calc,
	output logic resultValid,
	output calcPkg::bcdDigitT [`CALC_RES_DIGITS-1:0] resultDigits,
	output logic resultNeg
);

	localparam int BinW = `CALC_BIN_W;
	localparam int ResDigits = `CALC_RES_DIGITS;

	logic [BinW-1:0] wideA;
	logic [BinW-1:0] wideB;
	logic [BinW-1:0] binVal;
	logic negNext;
	calcPkg::bcdDigitT [ResDigits-1:0] digitsNext;

	assign wideA = BinW'(calc.opndA);
	assign wideB = BinW'(calc.opndB);

	always_comb begin
		negNext = 1'b0;
		case (calc.op)
			calcPkg::opAdd: binVal = wideA + wideB;
			calcPkg::opSub: begin
				// magnitude plus sign.
				if (wideB > wideA) begin
					binVal = wideB - wideA;
					negNext = 1'b1;
				end else begin
					binVal = wideA - wideB;
				end
			end
			calcPkg::opMul: binVal = wideA * wideB;
			default: binVal = '0;
		endcase
	end

	// units, tens, hundreds, thousands by repeated division.
	always_comb begin
		int scale;
		scale = 1;
		for (int i = 0; i < ResDigits; i++) begin
			digitsNext[i] = calcPkg::bcdDigitT'((binVal / scale) % 10);
			scale = scale * 10;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			resultValid <= 1'b0;
			resultDigits <= '0;
			resultNeg <= 1'b0;
		end else begin
			resultValid <= calc.go;
			if (calc.go) begin
				resultDigits <= digitsNext;   // held until the next result.
				resultNeg <= negNext;
			end
		end
	end

endmodule

/* source/calcTop.sv */
`include "calc_cfg.svh"

module calcTop (
	input logic clk,
	input logic rst,
	input logic keyValid,
	input logic [`CALC_CODE_W-1:0] scanCode,
	output logic resultValid,
	output calcPkg::bcdDigitT [`CALC_RES_DIGITS-1:0] resultDigits,   // thousands first.
	output logic resultNeg
);

	keyIf keyBus ();
	opIf opBus ();

	// make code to key, one cycle.
	keyDecode uDecode (
		.clk(clk),
		.rst(rst),
		.keyValid(keyValid),
		.scanCode(scanCode),
		.key(keyBus.src)
	);

	// entry FSM and operand registers, one cycle.
	calcExecute uExecute (
		.clk(clk),
		.rst(rst),
		.key(keyBus.dst),
		.calc(opBus.src)
	);

	// arithmetic and BCD conversion, one cycle.
	resultFormat uResult (
		.clk(clk),
		.rst(rst),
		.calc(opBus.dst),
		.resultValid(resultValid),
		.resultDigits(resultDigits),
		.resultNeg(resultNeg)
	);

endmodule

/* test/calc_asserts.sv */
`include "calc_cfg.svh"

module calcAsserts (
	input logic clk,
	input logic rst,
	input logic keyValid,
	input logic [`CALC_CODE_W-1:0] scanCode,
	input logic resultValid,
	input calcPkg::bcdDigitT [`CALC_RES_DIGITS-1:0] resultDigits
);

	logic enterStrobe;
	logic digitsOk;

	assign enterStrobe = keyValid && (scanCode == `CALC_KEY_ENTER);

	always_comb begin
		digitsOk = 1'b1;
		for (int i = 0; i < `CALC_RES_DIGITS; i++) begin
			if (resultDigits[i] > 4'd9) digitsOk = 1'b0;
		end
	end

	singlePulse: assert property (@(posedge clk) disable iff (rst) resultValid |=> !resultValid)
		else $error("resultValid high for two cycles in a row");

	// decode, execute and format each take one cycle.
	enterLatency: assert property (@(posedge clk) disable iff (rst)
		resultValid |-> $past(enterStrobe, 3))
		else $error("resultValid without an enter strobe three cycles earlier");

	bcdRange: assert property (@(posedge clk) disable iff (rst) resultValid |-> digitsOk)
		else $error("result digit above 9: %h", resultDigits);

endmodule

bind calcTop calcAsserts asserts (
	.clk(clk),
	.rst(rst),
	.keyValid(keyValid),
	.scanCode(scanCode),
	.resultValid(resultValid),
	.resultDigits(resultDigits)
);

/* test/calcTb.sv */
`include "calc_cfg.svh"

module calcTb;

	logic clk;
	logic rst;
	logic keyValid;
	logic [`CALC_CODE_W-1:0] scanCode;
	logic resultValid;
	calcPkg::bcdDigitT [`CALC_RES_DIGITS-1:0] resultDigits;
	logic resultNeg;

	int valueErrs;
	int timeoutErrs;
	int otherErrs;
	int seed;
	logic [15:0] heldDigits;   // last digits put out with resultValid.

	calcTop uut (
		.clk(clk),
		.rst(rst),
		.keyValid(keyValid),
		.scanCode(scanCode),
		.resultValid(resultValid),
		.resultDigits(resultDigits),
		.resultNeg(resultNeg)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// digits may only change together with resultValid.
	always @(negedge clk) begin
		if (rst || resultValid) begin
			heldDigits = resultDigits;
		end else if (resultDigits !== heldDigits) begin
			$display("ERR resultDigits held %h got %h", heldDigits, resultDigits);
			valueErrs++;
		end
	end

	function automatic logic [7:0] digitCode(input int d);
		case (d)
			0: return `CALC_KEY_0;
			1: return `CALC_KEY_1;
			2: return `CALC_KEY_2;
			3: return `CALC_KEY_3;
			4: return `CALC_KEY_4;
			5: return `CALC_KEY_5;
			6: return `CALC_KEY_6;
			7: return `CALC_KEY_7;
			8: return `CALC_KEY_8;
			default: return `CALC_KEY_9;
		endcase
	endfunction

	function automatic logic [7:0] opCode(input byte letter);
		case (letter)
			"s": return `CALC_KEY_SUB;
			"m": return `CALC_KEY_MUL;
			default: return `CALC_KEY_ADD;
		endcase
	endfunction

	// thousands digit lands in the top nibble.
	function automatic logic [15:0] decimalDigits(input int val);
		return {4'(val / 1000 % 10), 4'(val / 100 % 10), 4'(val / 10 % 10), 4'(val % 10)};
	endfunction

	task automatic pressKey(input logic [7:0] code);
		@(negedge clk);
		keyValid = 1'b1;
		scanCode = code;
		@(negedge clk);
		keyValid = 1'b0;   // one idle cycle before the next key.
		scanCode = 8'h00;
	endtask

	task automatic typeDigits(input string digits);
		for (int i = 0; i < digits.len(); i++) begin
			pressKey(digitCode(digits[i] - 8'h30));
		end
	endtask

	task automatic waitResult(output bit seen);
		int cycles;
		seen = 1'b0;
		cycles = 0;
		while (!seen && cycles < 20) begin
			@(negedge clk);
			if (resultValid) seen = 1'b1;
			cycles++;
		end
	endtask

	task automatic runCase(input string tag, input string aDigits, input byte opLetter,
			input string bDigits, input logic [15:0] expDigits, input logic expNeg);
		bit seen;
		byte otherOp;
		otherOp = (opLetter == "m") ? "a" : "m";
		typeDigits(aDigits);
		if (tag == "bad") pressKey(8'h11);   // no key uses this code.
		if (tag == "noop") begin
			pressKey(`CALC_KEY_ENTER);
			waitResult(seen);
			if (seen) begin
				$display("result appeared after enter with no operator, case %s %s", tag,
					aDigits);
				otherErrs++;
			end
		end
		pressKey(opCode(opLetter));
		if (tag == "twoop") pressKey(opCode(otherOp));
		typeDigits(bDigits);
		pressKey(`CALC_KEY_ENTER);
		waitResult(seen);
		if (!seen) begin
			$display("timed out waiting for resultValid, case %s %s%c%s", tag, aDigits,
				opLetter, bDigits);
			timeoutErrs++;
		end else begin
			if (resultDigits !== expDigits) begin
				$display("ERR resultDigits expected %h got %h (%s%c%s)", expDigits,
					resultDigits, aDigits, opLetter, bDigits);
				valueErrs++;
			end
			if (resultNeg !== expNeg) begin
				$display("ERR resultNeg expected %h got %h (%s%c%s)", expNeg, resultNeg,
					aDigits, opLetter, bDigits);
				valueErrs++;
			end
		end
	endtask

	initial begin
		int fd;
		int fields;
		int caseCount;
		int expNeg;
		int aVal;
		int bVal;
		int opPick;
		int val;
		string line;
		string tag;
		string aDigits;
		string opStr;
		string bDigits;
		logic [15:0] expDigits;
		logic negBit;
		byte opLetter;

		rst = 1'b1;
		keyValid = 1'b0;
		scanCode = 8'h00;
		valueErrs = 0;
		timeoutErrs = 0;
		otherErrs = 0;
		caseCount = 0;
		seed = 21756;
		repeat (8) @(negedge clk);
		rst = 1'b0;

		if (resultValid !== 1'b0) begin
			$display("ERR resultValid expected 0 got %h", resultValid);
			valueErrs++;
		end
		if (resultDigits !== 16'h0000) begin
			$display("ERR resultDigits expected 0000 got %h", resultDigits);
			valueErrs++;
		end
		if (resultNeg !== 1'b0) begin
			$display("ERR resultNeg expected 0 got %h", resultNeg);
			valueErrs++;
		end

		fd = $fopen("test/calc_cases.txt", "r");
		if (fd == 0) begin
			$display("could not open the cases file test/calc_cases.txt");
			otherErrs++;
		end else begin
			while (!$feof(fd)) begin
				line = "";
				fields = $fgets(line, fd);
				if (line.len() > 1 && line[0] != "#") begin
					fields = $sscanf(line, "%s %s %s %s %h %d", tag, aDigits, opStr, bDigits,
						expDigits, expNeg);
					if (fields == 6) begin
						runCase(tag, aDigits, opStr[0], bDigits, expDigits, expNeg[0]);
						caseCount++;
					end else begin
						$display("malformed line in cases file: %s", line);
						otherErrs++;
					end
				end
			end
			$fclose(fd);
		end
		if (caseCount == 0) begin
			$display("no cases were read from the cases file");
			otherErrs++;
		end

		// random operands checked against the arithmetic rule.
		for (int n = 0; n < 20; n++) begin
			aVal = {$random(seed)} % 100;
			bVal = {$random(seed)} % 100;
			opPick = {$random(seed)} % 3;
			negBit = 1'b0;
			if (opPick == 0) begin
				opLetter = "a";
				val = aVal + bVal;
			end else if (opPick == 1) begin
				opLetter = "s";
				val = aVal - bVal;
				negBit = (val < 0);
				if (negBit) val = -val;
			end else begin
				opLetter = "m";
				val = aVal * bVal;
			end
			runCase("rand", $sformatf("%0d", aVal), opLetter, $sformatf("%0d", bVal),
				decimalDigits(val), negBit);
		end

		repeat (4) @(negedge clk);
		$display("errors: %0d value, %0d timeout, %0d other", valueErrs, timeoutErrs,
			otherErrs);
		if (valueErrs + timeoutErrs + otherErrs == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

endmodule

/* tb.f */
+incdir+source
source/calcPkg.sv
source/keyIf.sv
source/opIf.sv
source/keyDecode.sv
source/calcExecute.sv
source/resultFormat.sv
source/calcTop.sv
test/calc_asserts.sv
test/calcTb.sv

/* test/calc_cases.txt */
# tag a-digits op(a=add s=sub m=mul) b-digits expected-bcd(hex) expected-sign
# tags: norm plain entry, bad unknown code after A, twoop extra operator, noop early enter
norm 47 a 85 0132 0
norm 12 s 57 0045 1
norm 57 s 12 0045 0
norm 99 m 99 9801 0
norm 347 a 5 0052 0
bad 6 m 7 0042 0
twoop 30 s 30 0000 0
noop 25 m 4 0100 0
norm 0 m 88 0000 0
norm 9 s 1234 0025 1
norm 99 a 99 0198 0
bad 80 s 8 0072 0
twoop 3 a 4 0007 0
